//--- bench/vga_pattern_input.txt
// pattern code (0 bars, 1 reverse, 2 white), bar column, expected rgb word
// rgb holds red, green, blue at four bits each, levels 1 and b
0 0 bbb
0 1 bb1
0 2 1bb
0 3 1b1
0 4 b1b
0 5 b11
0 6 11b
0 7 111
1 0 111
1 1 11b
1 2 b11
1 3 b1b
1 4 1b1
1 5 1bb
1 6 bb1
1 7 bbb
2 0 bbb
2 1 bbb
2 2 bbb
2 3 bbb
2 4 bbb
2 5 bbb
2 6 bbb
2 7 bbb

//--- verilog.f
+incdir+include
hdl/vga_pkg.sv
hdl/color_bar_source.sv
hdl/pixel_fifo.sv
hdl/vga_scanout.sv
hdl/vga_pattern_top.sv
bench/tb_vga_pattern.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_vga_pattern
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_vga_pattern.sv
`timescale 1ns/1ns

module tb_vga_pattern;
  import vga_pkg::*;

  logic                   clk;
  logic                   rst_n;
  pattern_e               pattern;
  logic [color_width-1:0] vga_red;
  logic [color_width-1:0] vga_grn;
  logic [color_width-1:0] vga_blu;
  logic                   vga_hsync;
  logic                   vga_vsync;
  logic                   vga_error;

  // three words per line of the data file
  logic [11:0] stim [72];
  logic [11:0] exp_color [8];

  // output position recovered from the sync edges
  int   out_x       = 0;
  int   out_line    = 0;
  int   frame_count = 0;
  logic locked_h    = 1'b0;
  logic locked_v    = 1'b0;

  // frame and line range where the monitor compares bar colours
  int   chk_frame = -1;
  int   chk_lo    = 0;
  int   chk_hi    = 0;
  int   n_checked = 0;

  vga_pattern_top i_vga_pattern_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .pattern   (pattern),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_error (vga_error)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  // samples the outputs at the falling edge halfway between updates
  initial begin : scan_monitor
    logic        hs_prev;
    logic        vs_prev;
    int          hs_low;
    int          hs_since;
    int          vs_low;
    int          vs_since;
    int          vs_gap;
    logic [11:0] rgb;
    logic [2:0]  col;
    hs_prev  = 1'b1;
    vs_prev  = 1'b1;
    hs_low   = 0;
    vs_low   = 0;
    // -1 until the first edge has been seen
    hs_since = -1;
    vs_since = -1;
    vs_gap   = -1;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      rgb = {vga_red, vga_grn, vga_blu};
      check_value(32'(vga_error), 0, "stream error flag raised");
      if (locked_h) begin
        out_x = (out_x + 1) % 48;
        if (out_x == 0 && locked_v)
          out_line = (out_line + 1) % 12;
      end
      if (hs_since >= 0)
        hs_since = hs_since + 1;
      if (vs_since >= 0)
        vs_since = vs_since + 1;
      if (vs_gap >= 0)
        vs_gap = vs_gap + 1;

      if (vga_hsync === 1'b0) begin
        hs_low = hs_low + 1;
      end else if (hs_prev === 1'b0) begin
        // rising hsync marks output x 40
        check_value(hs_low, 4, "hsync low width");
        if (hs_since >= 0)
          check_value(hs_since, 48, "hsync period");
        out_x    = 40;
        locked_h = 1'b1;
        hs_low   = 0;
        hs_since = 0;
      end

      if (vga_vsync === 1'b0) begin
        vs_low = vs_low + 1;
        if (vs_prev === 1'b1) begin
          // falling vsync at the start of line 9
          if (locked_v)
            check_value(out_line * 48 + out_x, 9 * 48, "vsync fall position");
          vs_gap = 0;
        end
      end else if (vs_prev === 1'b0) begin
        check_value(vs_low, 96, "vsync low width");
        if (vs_since >= 0)
          check_value(vs_since, 576, "vsync period");
        check_value(out_x, 0, "vsync edge inside a line");
        out_line = 11;
        locked_v = 1'b1;
        vs_low   = 0;
        vs_since = 0;
      end
      hs_prev = vga_hsync;
      vs_prev = vga_vsync;

      // three lines from the vsync fall to the first visible pixel
      if (vs_gap >= 0 && rgb != '0) begin
        check_value(vs_gap, 144, "vsync start to visible area");
        vs_gap = -1;
      end

      if (locked_h && locked_v) begin
        if (out_x == 0 && out_line == 0)
          frame_count = frame_count + 1;
        if (out_x >= 32 || out_line >= 8) begin
          check_value(32'(rgb), 0, $sformatf("blanking at x %0d line %0d", out_x, out_line));
        end else if (frame_count == chk_frame && out_line >= chk_lo && out_line <= chk_hi &&
                     out_x % 4 == 2) begin
          col = 3'(out_x / 4);
          check_value(32'(rgb), 32'(exp_color[col]),
                      $sformatf("colour at x %0d line %0d", out_x, out_line));
          n_checked = n_checked + 1;
        end
      end
    end
  end

  initial begin : main_sequence
    int         g;
    int         k;
    int         row;
    logic [2:0] col;
    rst_n = 1'b0;
    $readmemh("bench/vga_pattern_input.txt", stim);
    if ($isunknown(stim[71])) begin
      $display("the stimulus file bench/vga_pattern_input.txt is missing or incomplete");
      $display("*** FAILED ***");
      $fatal(1, "no stimulus");
    end
    pattern = pattern_e'(stim[0][1:0]);

    // syncs high, rgb and error low in reset and the cycle after it
    for (k = 0; k < 6; k++) begin
      @(negedge clk);
      check_value(32'({vga_hsync, vga_vsync, vga_error, vga_red, vga_grn, vga_blu}),
                  32'h6000, "output state around reset");
      if (k == 4)
        rst_n = 1'b1;
    end

    wait (locked_h && locked_v);
    for (g = 0; g < 3; g++) begin
      row = 24 * g;
      if (g > 0) begin
        // switch during line 3 so line 4 must still carry the old pattern
        wait (out_line == 3);
        chk_frame = frame_count;
        chk_lo    = 4;
        chk_hi    = 4;
        n_checked = 0;
        @(negedge clk);
        pattern = pattern_e'(stim[7'(row)][1:0]);
        wait (out_line == 5);
        check_value(n_checked, 8, "samples on the line after a mid-frame switch");
      end
      for (k = 0; k < 8; k++) begin
        col = 3'(stim[7'(row + 3 * k + 1)]);
        exp_color[col] = stim[7'(row + 3 * k + 2)];
      end
      // second frame start after the change
      chk_frame = frame_count + 2;
      chk_lo    = 0;
      chk_hi    = 7;
      n_checked = 0;
      wait (frame_count == chk_frame + 1);
      check_value(n_checked, 64, "colour samples in one frame");
    end
    $display("*** PASSED ***");
    $finish;
  end

  initial begin : watchdog
    int test_frames;
    int limit_ns;
    // one frame to lock, up to four per pattern, one spare
    test_frames = 4 * 3 + 2;
    limit_ns    = 2 * test_frames * 576 * 10;
    #(limit_ns);
    $display("timeout: the test sequence did not finish within %0d ns", limit_ns);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- hdl/vga_pattern_top.sv
`timescale 1ns/1ns

module vga_pattern_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  vga_pkg::pattern_e               pattern,
  output logic [vga_pkg::color_width-1:0] vga_red,
  output logic [vga_pkg::color_width-1:0] vga_grn,
  output logic [vga_pkg::color_width-1:0] vga_blu,
  output logic                            vga_hsync,
  output logic                            vga_vsync,
  output logic                            vga_error
);
  import vga_pkg::*;

  // producer side of the fifo
  logic                   src_valid;
  logic                   src_ready;
  logic [color_width-1:0] src_red;
  logic [color_width-1:0] src_grn;
  logic [color_width-1:0] src_blu;
  logic [h_width-1:0]     src_x;
  logic [v_width-1:0]     src_y;
  logic [fifo_width-1:0]  src_word;

  // scan-out side of the fifo
  logic                   out_valid;
  logic                   out_ready;
  logic [color_width-1:0] out_red;
  logic [color_width-1:0] out_grn;
  logic [color_width-1:0] out_blu;
  logic [h_width-1:0]     out_x;
  logic [v_width-1:0]     out_y;
  logic [fifo_width-1:0]  out_word;

  assign src_word = {src_red, src_grn, src_blu, src_x, src_y};
  assign {out_red, out_grn, out_blu, out_x, out_y} = out_word;

  color_bar_source i_color_bar_source (
    .clk       (clk),
    .rst_n     (rst_n),
    .pattern   (pattern),
    .pix_valid (src_valid),
    .pix_ready (src_ready),
    .pix_red   (src_red),
    .pix_grn   (src_grn),
    .pix_blu   (src_blu),
    .pix_x     (src_x),
    .pix_y     (src_y)
  );

  pixel_fifo i_pixel_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (src_valid),
    .in_ready  (src_ready),
    .in_data   (src_word),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_word)
  );

  vga_scanout i_vga_scanout (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix_valid (out_valid),
    .pix_ready (out_ready),
    .pix_red   (out_red),
    .pix_grn   (out_grn),
    .pix_blu   (out_blu),
    .pix_x     (out_x),
    .pix_y     (out_y),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_error (vga_error)
  );

endmodule

//--- hdl/vga_scanout.sv
`timescale 1ns/1ns

module vga_scanout (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            pix_valid,
  output logic                            pix_ready,
  input  logic [vga_pkg::color_width-1:0] pix_red,
  input  logic [vga_pkg::color_width-1:0] pix_grn,
  input  logic [vga_pkg::color_width-1:0] pix_blu,
  input  logic [vga_pkg::h_width-1:0]     pix_x,
  input  logic [vga_pkg::v_width-1:0]     pix_y,
  output logic [vga_pkg::color_width-1:0] vga_red,
  output logic [vga_pkg::color_width-1:0] vga_grn,
  output logic [vga_pkg::color_width-1:0] vga_blu,
  output logic                            vga_hsync,
  output logic                            vga_vsync,
  output logic                            vga_error
);
  import vga_pkg::*;

  typedef enum logic {
    st_wait,
    st_run
  } state_e;

  state_e             state;

  logic [h_width-1:0] h_cnt;
  logic [v_width-1:0] v_cnt;

  logic               h_last;
  logic               v_last;
  logic               visible;
  logic               hsync_area;
  logic               vsync_area;
  logic               pix_bad;

  assign h_last  = (h_cnt == h_line_end - 1'b1);
  assign v_last  = (v_cnt == v_frame_end - 1'b1);
  assign visible = (state == st_run) && (h_cnt < h_visible) && (v_cnt < v_visible);

  assign hsync_area = (h_cnt >= h_sync_start) && (h_cnt < h_sync_end);
  assign vsync_area = (v_cnt >= v_sync_start) && (v_cnt < v_sync_end);

  // pop exactly one pixel per visible position
  assign pix_ready = visible;

  // missing pixel, or the stream has slipped against the beam
  assign pix_bad = !pix_valid || (pix_x != h_cnt) || (pix_y != v_cnt);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_wait;
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      case (state)
        st_wait: begin
          // hold at (0,0) until the first pixel shows up
          if (pix_valid) begin
            state <= st_run;
          end
        end
        st_run: begin
          if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
              v_cnt <= '0;
            end else begin
              v_cnt <= v_cnt + 1'b1;
            end
          end else begin
            h_cnt <= h_cnt + 1'b1;
          end
        end
        default: state <= st_wait;
      endcase
    end
  end

  // output stage, one cycle behind the counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_error <= 1'b0;
    end else begin
      vga_hsync <= !hsync_area;
      vga_vsync <= !vsync_area;

      if (visible) begin
        vga_red <= pix_red;
        vga_grn <= pix_grn;
        vga_blu <= pix_blu;
      end else begin
        vga_red <= '0;
        vga_grn <= '0;
        vga_blu <= '0;
      end

      // sticky until reset
      if (visible && pix_bad) begin
        vga_error <= 1'b1;
      end
    end
  end

  // registered sync lags the counter, so check across that cycle
  a_hsync_not_visible : assert property (
    @(posedge clk) disable iff (!rst_n)
    (h_cnt < h_visible) |-> vga_hsync
  );

endmodule

//--- hdl/pixel_fifo.sv
`timescale 1ns/1ns

module pixel_fifo (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           in_valid,
  output logic                           in_ready,
  input  logic [vga_pkg::fifo_width-1:0] in_data,
  output logic                           out_valid,
  input  logic                           out_ready,
  output logic [vga_pkg::fifo_width-1:0] out_data
);
  import vga_pkg::*;

  logic [fifo_width-1:0]     mem [fifo_depth];

  logic [fifo_ptr_width-1:0] wr_ptr;
  logic [fifo_ptr_width-1:0] rd_ptr;
  logic [fifo_ptr_width-1:0] rd_ptr_next;
  logic [fifo_cnt_width-1:0] count;
  logic [fifo_cnt_width-1:0] count_after_pop;
  logic [fifo_cnt_width-1:0] count_next;

  logic                      push;
  logic                      pop;

  assign pop      = out_valid && out_ready;
  // a full fifo still takes a word when the head leaves the same cycle
  assign in_ready = (count != fifo_cnt_width'(fifo_depth)) || pop;
  assign push     = in_valid && in_ready;

  assign rd_ptr_next     = pop ? rd_ptr + 1'b1 : rd_ptr;
  assign count_after_pop = pop ? count - 1'b1 : count;
  assign count_next      = push ? count_after_pop + 1'b1 : count_after_pop;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr    <= rd_ptr_next;
      count     <= count_next;
      out_valid <= (count_next != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // the head register loads straight from the input when nothing else is queued
  always_ff @(posedge clk) begin
    if (count_after_pop == '0) begin
      out_data <= in_data;
    end else begin
      out_data <= mem[rd_ptr_next];
    end
  end

  a_count_bound : assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= fifo_cnt_width'(fifo_depth)
  );

  // equal pointers mean empty unless the buffer is full
  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (!rst_n)
    pop |-> (rd_ptr != wr_ptr) || (count == fifo_cnt_width'(fifo_depth))
  );

endmodule

//--- hdl/color_bar_source.sv
`timescale 1ns/1ns

module color_bar_source (
  input  logic                            clk,
  input  logic                            rst_n,
  input  vga_pkg::pattern_e               pattern,
  output logic                            pix_valid,
  input  logic                            pix_ready,
  output logic [vga_pkg::color_width-1:0] pix_red,
  output logic [vga_pkg::color_width-1:0] pix_grn,
  output logic [vga_pkg::color_width-1:0] pix_blu,
  output logic [vga_pkg::h_width-1:0]     pix_x,
  output logic [vga_pkg::v_width-1:0]     pix_y
);
  import vga_pkg::*;

  // scan position of the pixel on offer
  logic [h_width-1:0]     x;
  logic [v_width-1:0]     y;

  // current column and the x where the next one begins
  logic [bar_bits-1:0]    col;
  logic [h_width-1:0]     col_edge;

  pattern_e               frame_pat;
  logic [pixel_width-1:0] color;

  logic                   xfer;
  logic                   last_x;
  logic                   last_pixel;

  assign xfer       = pix_valid && pix_ready;
  assign last_x     = (x == h_visible - 1'b1);
  assign last_pixel = last_x && (y == v_visible - 1'b1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_valid <= 1'b0;
      x         <= '0;
      y         <= '0;
      col       <= '0;
      col_edge  <= bar_width;
      frame_pat <= pat_bars;
    end else begin
      // one idle cycle after reset, then always offering a pixel
      pix_valid <= 1'b1;

      // pick up the selection just before pixel (0,0) goes out
      if (!pix_valid || (xfer && last_pixel)) begin
        frame_pat <= pattern;
      end

      if (xfer) begin
        if (last_x) begin
          x        <= '0;
          col      <= '0;
          col_edge <= bar_width;
          if (y == v_visible - 1'b1) begin
            y <= '0;
          end else begin
            y <= y + 1'b1;
          end
        end else begin
          x <= x + 1'b1;
          if (x == col_edge - 1'b1) begin
            col      <= col + 1'b1;
            col_edge <= col_edge + bar_width;
          end
        end
      end
    end
  end

  always_comb begin
    case (frame_pat)
      pat_white:   color = color_white;
      // bar_count is a power of two so inverting the index mirrors it
      pat_reverse: color = bar_colors[~col];
      default:     color = bar_colors[col];
    endcase
  end

  assign {pix_red, pix_grn, pix_blu} = color;
  assign pix_x                       = x;
  assign pix_y                       = y;

  // a stalled pixel must not move until the consumer takes it
  a_hold_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    pix_valid && !pix_ready |=>
      pix_valid && $stable({pix_red, pix_grn, pix_blu, pix_x, pix_y})
  );

endmodule

//--- hdl/vga_pkg.sv
`include "vga_color.svh"

package vga_pkg;

  // data widths
  localparam int color_width = 4;
  localparam int pixel_width = 3 * color_width;
  localparam int h_width     = 8;
  localparam int v_width     = 8;

  // horizontal timing in pixels
  localparam logic [h_width-1:0] h_visible    = 8'd32;
  localparam logic [h_width-1:0] h_sync_start = 8'd36;
  localparam logic [h_width-1:0] h_sync_end   = 8'd40;
  localparam logic [h_width-1:0] h_line_end   = 8'd48;

  // vertical timing in lines
  localparam logic [v_width-1:0] v_visible    = 8'd8;
  localparam logic [v_width-1:0] v_sync_start = 8'd9;
  localparam logic [v_width-1:0] v_sync_end   = 8'd11;
  localparam logic [v_width-1:0] v_frame_end  = 8'd12;

  // bar geometry, eight equal columns across the visible width
  localparam int                 bar_count = 8;
  localparam int                 bar_bits  = $clog2(bar_count);
  localparam logic [h_width-1:0] bar_width = h_visible >> bar_bits;

  // 75 percent levels taken from the 10-bit smpte values
  localparam logic [color_width-1:0] c_off =
    color_width'(`VGA_COLOR_SCALE(64, 10, color_width));
  localparam logic [color_width-1:0] c_on =
    color_width'(`VGA_COLOR_SCALE(721, 10, color_width));

  // colour words, red in the top bits
  localparam logic [pixel_width-1:0] color_white   = {c_on, c_on, c_on};
  localparam logic [pixel_width-1:0] color_yellow  = {c_on, c_on, c_off};
  localparam logic [pixel_width-1:0] color_cyan    = {c_off, c_on, c_on};
  localparam logic [pixel_width-1:0] color_green   = {c_off, c_on, c_off};
  localparam logic [pixel_width-1:0] color_magenta = {c_on, c_off, c_on};
  localparam logic [pixel_width-1:0] color_red     = {c_on, c_off, c_off};
  localparam logic [pixel_width-1:0] color_blue    = {c_off, c_off, c_on};
  localparam logic [pixel_width-1:0] color_black   = {c_off, c_off, c_off};

  // index 0 is the leftmost bar
  localparam logic [bar_count-1:0][pixel_width-1:0] bar_colors = {
    color_black, color_blue, color_red, color_magenta,
    color_green, color_cyan, color_yellow, color_white
  };

  // pattern select, code 3 falls back to the forward bars
  typedef enum logic [1:0] {
    pat_bars    = 2'd0,
    pat_reverse = 2'd1,
    pat_white   = 2'd2
  } pattern_e;

  // pixel fifo, word is colour then x then y
  localparam int fifo_depth     = 8;
  localparam int fifo_width     = pixel_width + h_width + v_width;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  localparam int fifo_cnt_width = $clog2(fifo_depth + 1);

endpackage

//--- include/vga_color.svh
`ifndef VGA_COLOR_SVH
`define VGA_COLOR_SVH

// rescale an m-bit colour component to n bits, rounding to nearest
// full scale maps to full scale, e.g. 1023 at 10 bits gives 15 at 4 bits
`define VGA_COLOR_SCALE(val, m, n) \
  ((((val) * ((1 << (n)) - 1)) + ((1 << ((m) - 1)) - 1)) / ((1 << (m)) - 1))

`endif
